// ==== hdl/bypassSelect.sv ====
`timescale 1ns/1ps
`default_nettype none

module bypassSelect import regPkg::*, ctrlPkg::*; (
	input  regNumT idRs,
	input  regNumT idRt,
	input  regNumT idRsCmp,
	input  regNumT idRtCmp,
	input  logic   idMux3Sel,	// rt operand taken from immediate path
	input  logic   alu1Sel,	// rs operand taken from shamt/PC path

	input  regNumT exRd,
	input  logic   exRfWr,
	input  logic   exLd,
	input  regNumT mem1Rd,
	input  logic   mem1RfWr,
	input  logic   mem1Ld,
	input  regNumT mem2Rd,
	input  logic   mem2RfWr,
	input  logic   mem2Ld,
	input  regNumT wbRd,
	input  logic   wbRfWr,

	output fwdSelT rsExSel,
	output fwdSelT rtExSel,
	output fwdSelT rsIdSel,
	output fwdSelT rtIdSel,
	output fwdSelT rsCmpSel,
	output fwdSelT rtCmpSel,
	output fwdSelT rsAluSel,
	output fwdSelT rtAluSel
);

	// Late writers still forward their code; stallControl holds ID
	// until the loaded value has actually reached the selected stage

	// Operand entering EX next cycle, youngest writer first
	function automatic fwdSelT exPathSel(input regNumT src);
		fwdSelT sel;
		if (exRfWr && (exRd == src)) begin
			sel = SEL_EX;
		end else if (mem1RfWr && (mem1Rd == src)) begin
			sel = SEL_MEM1;
		end else if (mem2RfWr && (mem2Rd == src)) begin
			sel = SEL_MEM2;
		end else begin
			sel = SEL_NONE;
		end
		return sel;
	endfunction

	// Operand used inside ID, EX result not yet available
	function automatic fwdSelT idPathSel(input regNumT src);
		fwdSelT sel;
		if (mem1RfWr && (mem1Rd == src)) begin
			sel = SEL_MEM1;
		end else if (mem2RfWr && (mem2Rd == src)) begin
			sel = SEL_MEM2;
		end else if (wbRfWr && (wbRd == src)) begin
			sel = SEL_WB;
		end else begin
			sel = SEL_NONE;
		end
		return sel;
	endfunction

	always_comb begin
		rsExSel  = exPathSel(idRs);
		rtExSel  = exPathSel(idRt);
		rsIdSel  = idPathSel(idRs);
		rtIdSel  = idPathSel(idRt);
		rsCmpSel = idPathSel(idRsCmp);	// Branch comparator ports
		rtCmpSel = idPathSel(idRtCmp);
		// ALU inputs skip the bypass when fed from elsewhere
		rsAluSel = alu1Sel   ? SEL_NONE : rsExSel;
		rtAluSel = idMux3Sel ? SEL_NONE : rtExSel;
	end

endmodule

`default_nettype wire

// ==== hdl/ctrlPkg.sv ====
`default_nettype none

// Control side of the hazard logic: forwarding mux select codes
package ctrlPkg;

	localparam int FWD_W = 2;	// Select width of every bypass mux

	typedef logic [FWD_W-1:0] fwdSelT;

	localparam fwdSelT SEL_NONE = 2'b00;	// Register file value

	// Operands entering EX
	localparam fwdSelT SEL_EX   = 2'b01;	// EX result, via MEM1 pipe reg
	localparam fwdSelT SEL_MEM1 = 2'b10;	// MEM1 result, via MEM2 pipe reg
	localparam fwdSelT SEL_MEM2 = 2'b11;	// MEM2 result, via WB pipe reg

	// Operands used in ID (compare and ID read ports)
	// MEM1 and MEM2 keep the codes above; WB reuses 01 since EX never feeds ID
	localparam fwdSelT SEL_WB   = 2'b01;

endpackage

`default_nettype wire

// ==== hdl/hazardTop.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardTop import regPkg::*, ctrlPkg::*; (
	input  logic   clk,
	input  logic   arstN,

	input  logic   idValid,
	input  regNumT idRs,
	input  regNumT idRt,
	input  regNumT idRsCmp,
	input  regNumT idRtCmp,
	input  regNumT idRd,
	input  logic   idRfWr,
	input  logic   idDmRd,
	input  logic   idCp0Rd,
	input  logic   idBjOp,
	input  logic   idMux3Sel,
	input  logic   alu1Sel,

	input  logic   iCacheDataOk,
	input  logic   dCacheDataOk,
	input  logic   mem1WaitOp,
	input  logic   mulBusy,
	input  logic   mem1Exc,

	output fwdSelT rsExSel,
	output fwdSelT rtExSel,
	output fwdSelT rsIdSel,
	output fwdSelT rtIdSel,
	output fwdSelT rsCmpSel,
	output fwdSelT rtCmpSel,
	output fwdSelT rsAluSel,
	output fwdSelT rtAluSel,

	output logic   pcWr,
	output logic   pfIfWr,
	output logic   ifIdWr,
	output logic   idExWr,
	output logic   exMem1Wr,
	output logic   mem1Mem2Wr,
	output logic   mem2WbWr,
	output logic   bubbleSel,
	output logic   dataStall,
	output logic   wholeStall
);

	// Writer records of the in-flight instructions
	regNumT exRd, mem1Rd, mem2Rd, wbRd;
	logic   exRfWr, exLd, mem1RfWr, mem1Ld, mem2RfWr, mem2Ld, wbRfWr;

	issueTracker uTracker (
		.clk        (clk),
		.arstN      (arstN),
		.idValid    (idValid),
		.idRd       (idRd),
		.idRfWr     (idRfWr),
		.idDmRd     (idDmRd),
		.idCp0Rd    (idCp0Rd),
		.idExWr     (idExWr),
		.exMem1Wr   (exMem1Wr),
		.mem1Mem2Wr (mem1Mem2Wr),
		.mem2WbWr   (mem2WbWr),
		.bubbleSel  (bubbleSel),
		.mem1Exc    (mem1Exc),
		.exRd       (exRd),
		.exRfWr     (exRfWr),
		.exLd       (exLd),
		.mem1Rd     (mem1Rd),
		.mem1RfWr   (mem1RfWr),
		.mem1Ld     (mem1Ld),
		.mem2Rd     (mem2Rd),
		.mem2RfWr   (mem2RfWr),
		.mem2Ld     (mem2Ld),
		.wbRd       (wbRd),
		.wbRfWr     (wbRfWr)
	);

	bypassSelect uBypass (
		.idRs      (idRs),
		.idRt      (idRt),
		.idRsCmp   (idRsCmp),
		.idRtCmp   (idRtCmp),
		.idMux3Sel (idMux3Sel),
		.alu1Sel   (alu1Sel),
		.exRd      (exRd),
		.exRfWr    (exRfWr),
		.exLd      (exLd),
		.mem1Rd    (mem1Rd),
		.mem1RfWr  (mem1RfWr),
		.mem1Ld    (mem1Ld),
		.mem2Rd    (mem2Rd),
		.mem2RfWr  (mem2RfWr),
		.mem2Ld    (mem2Ld),
		.wbRd      (wbRd),
		.wbRfWr    (wbRfWr),
		.rsExSel   (rsExSel),
		.rtExSel   (rtExSel),
		.rsIdSel   (rsIdSel),
		.rtIdSel   (rtIdSel),
		.rsCmpSel  (rsCmpSel),
		.rtCmpSel  (rtCmpSel),
		.rsAluSel  (rsAluSel),
		.rtAluSel  (rtAluSel)
	);

	stallControl uStall (
		.idValid      (idValid),
		.idRs         (idRs),
		.idRt         (idRt),
		.idBjOp       (idBjOp),
		.exRd         (exRd),
		.exRfWr       (exRfWr),
		.exLd         (exLd),
		.mem1Rd       (mem1Rd),
		.mem1RfWr     (mem1RfWr),
		.mem1Ld       (mem1Ld),
		.mem2Rd       (mem2Rd),
		.mem2RfWr     (mem2RfWr),
		.mem2Ld       (mem2Ld),
		.iCacheDataOk (iCacheDataOk),
		.dCacheDataOk (dCacheDataOk),
		.mem1WaitOp   (mem1WaitOp),
		.mulBusy      (mulBusy),
		.mem1Exc      (mem1Exc),
		.pcWr         (pcWr),
		.pfIfWr       (pfIfWr),
		.ifIdWr       (ifIdWr),
		.idExWr       (idExWr),
		.exMem1Wr     (exMem1Wr),
		.mem1Mem2Wr   (mem1Mem2Wr),
		.mem2WbWr     (mem2WbWr),
		.bubbleSel    (bubbleSel),
		.dataStall    (dataStall),
		.wholeStall   (wholeStall)
	);

endmodule

`default_nettype wire

// ==== hdl/issueTracker.sv ====
`timescale 1ns/1ps
`default_nettype none

module issueTracker import regPkg::*; (
	input  logic   clk,
	input  logic   arstN,

	input  logic   idValid,
	input  regNumT idRd,
	input  logic   idRfWr,
	input  logic   idDmRd,
	input  logic   idCp0Rd,

	input  logic   idExWr,
	input  logic   exMem1Wr,
	input  logic   mem1Mem2Wr,
	input  logic   mem2WbWr,
	input  logic   bubbleSel,
	input  logic   mem1Exc,

	output regNumT exRd,
	output logic   exRfWr,
	output logic   exLd,
	output regNumT mem1Rd,
	output logic   mem1RfWr,
	output logic   mem1Ld,
	output regNumT mem2Rd,
	output logic   mem2RfWr,
	output logic   mem2Ld,
	output regNumT wbRd,
	output logic   wbRfWr
);

	logic exSquash;	// EX receives a bubble
	logic idWrites;	// ID instruction really writes a GPR

	assign exSquash = bubbleSel | ~idValid | mem1Exc;
	assign idWrites = idRfWr & (idRd != REG_ZERO);	// $zero dropped here only

	// Control flags, cleared to an empty pipe
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exRfWr   <= 1'b0;
			exLd     <= 1'b0;
			mem1RfWr <= 1'b0;
			mem1Ld   <= 1'b0;
			mem2RfWr <= 1'b0;
			mem2Ld   <= 1'b0;
			wbRfWr   <= 1'b0;
		end else begin
			if (idExWr) begin
				exRfWr <= exSquash ? 1'b0 : idWrites;
				exLd   <= exSquash ? 1'b0 : (idDmRd | idCp0Rd);	// Late result
			end
			if (exMem1Wr) begin
				mem1RfWr <= mem1Exc ? 1'b0 : exRfWr;	// Squash faulting EX
				mem1Ld   <= mem1Exc ? 1'b0 : exLd;
			end
			if (mem1Mem2Wr) begin
				mem2RfWr <= mem1RfWr;
				mem2Ld   <= mem1Ld;
			end
			if (mem2WbWr) begin
				wbRfWr <= mem2RfWr;
			end
		end
	end

	// Destination register numbers of the four stages
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			exRd   <= REG_ZERO;
			mem1Rd <= REG_ZERO;
			mem2Rd <= REG_ZERO;
			wbRd   <= REG_ZERO;
		end else begin
			if (idExWr) begin
				exRd <= idRd;
			end
			if (exMem1Wr) begin
				mem1Rd <= exRd;
			end
			if (mem1Mem2Wr) begin
				mem2Rd <= mem1Rd;
			end
			if (mem2WbWr) begin
				wbRd <= mem2Rd;
			end
		end
	end

endmodule

`default_nettype wire

// ==== hdl/regPkg.sv ====
`default_nettype none

// Register-file side of the hazard logic: register numbers and the
// fields a stage's writer record is built from
package regPkg;

	localparam int REG_W = 5;	// GPR index width

	typedef logic [REG_W-1:0] regNumT;	// One architectural register number

	localparam regNumT REG_ZERO = regNumT'(0);	// $zero, never a writer

	// Writer record of one stage, carried as separate signals
	//   rd   destination register
	//   rfWr will write rd, already false for $zero
	//   ld   result comes late (data memory or CP0 read)

endpackage

`default_nettype wire

// ==== hdl/stallControl.sv ====
`timescale 1ns/1ps
`default_nettype none

module stallControl import regPkg::*; (
	input  logic   idValid,
	input  regNumT idRs,
	input  regNumT idRt,
	input  logic   idBjOp,	// Branch/jump resolved in ID

	input  regNumT exRd,
	input  logic   exRfWr,
	input  logic   exLd,
	input  regNumT mem1Rd,
	input  logic   mem1RfWr,
	input  logic   mem1Ld,
	input  regNumT mem2Rd,
	input  logic   mem2RfWr,
	input  logic   mem2Ld,

	input  logic   iCacheDataOk,
	input  logic   dCacheDataOk,
	input  logic   mem1WaitOp,
	input  logic   mulBusy,
	input  logic   mem1Exc,

	output logic   pcWr,
	output logic   pfIfWr,
	output logic   ifIdWr,
	output logic   idExWr,
	output logic   exMem1Wr,
	output logic   mem1Mem2Wr,
	output logic   mem2WbWr,
	output logic   bubbleSel,
	output logic   dataStall,
	output logic   wholeStall
);

	logic exHit;
	logic mem1Hit;
	logic mem2Hit;

	// A writer matching either ID source register
	assign exHit   = exRfWr & ((exRd == idRs) | (exRd == idRt));
	assign mem1Hit = mem1RfWr & ((mem1Rd == idRs) | (mem1Rd == idRt));
	assign mem2Hit = mem2RfWr & ((mem2Rd == idRs) | (mem2Rd == idRt));

	// Loads resolve in MEM2; branches need operands already in ID
	assign dataStall = idValid & ((exHit & (exLd | idBjOp))
		| (mem1Hit & mem1Ld)
		| (mem2Hit & mem2Ld & idBjOp));

	assign wholeStall = ~iCacheDataOk | ~dCacheDataOk | mem1WaitOp | mulBusy;

	always_comb begin
		{pcWr, pfIfWr, ifIdWr, idExWr} = 4'b1111;	// Default: free running
		{exMem1Wr, mem1Mem2Wr, mem2WbWr} = 3'b111;
		bubbleSel = 1'b0;
		if (mem1Exc) begin
			// Flush path; the older stages still wait for the D-cache
			mem1Mem2Wr = dCacheDataOk;
			mem2WbWr   = dCacheDataOk;
		end else if (wholeStall) begin
			{pcWr, pfIfWr, ifIdWr, idExWr} = 4'b0000;	// Freeze everything
			{exMem1Wr, mem1Mem2Wr, mem2WbWr} = 3'b000;
		end else if (dataStall) begin
			{pcWr, pfIfWr, ifIdWr} = 3'b000;	// Hold front end
			bubbleSel = 1'b1;	// Insert bubble into EX
		end
	end

endmodule

`default_nettype wire

// ==== run.sh ====
#!/bin/sh
# Compile and run the hazard-control testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
	--top-module hazardTop_tb \
	--Mdir obj_dir -o simv \
	-f verilog.f
status=$?
if [ $status -ne 0 ]; then
	echo "Verilator build failed with status $status"
	exit 1
fi

output=$(./obj_dir/simv)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -q "^RESULT: PASS$"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

// ==== sim/hazardTop_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardTop_assert (
	input wire logic pcWr,
	input wire logic bubbleSel,
	input wire logic dataStall,
	input wire logic wholeStall,
	input wire logic mem1Exc
);

	// Sampling clock, edges fall between the testbench's input changes
	logic sampleClk = 1'b0;

	always #5 sampleClk = ~sampleClk;

	bubbleNeedsStall: assert property (@(posedge sampleClk) bubbleSel |-> dataStall)
		else $error("bubbleSel without dataStall");

	stallHoldsPc: assert property (@(posedge sampleClk) (wholeStall && !mem1Exc) |-> !pcWr)
		else $error("pcWr high during wholeStall");

	excRedirectsPc: assert property (@(posedge sampleClk) mem1Exc |-> pcWr)
		else $error("pcWr low on mem1Exc");	// Fetch must restart at the handler

endmodule

bind stallControl hazardTop_assert uAssert (
	.pcWr       (pcWr),
	.bubbleSel  (bubbleSel),
	.dataStall  (dataStall),
	.wholeStall (wholeStall),
	.mem1Exc    (mem1Exc)
);

`default_nettype wire

// ==== sim/hazardTop_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module hazardTop_tb import regPkg::*, ctrlPkg::*; ();

	localparam int RESET_CYCLES = 8;
	localparam int N_FIXED = 16;
	localparam int N_ROWS = N_FIXED + 24;
	localparam int TIMEOUT_CYCLES = N_ROWS + RESET_CYCLES + 20;
	localparam logic [6:0] EN_ALL = 7'b1111111;	// {pc,pfIf,ifId,idEx,exMem1,mem1Mem2,mem2Wb}
	localparam logic [6:0] EN_DATA = 7'b0001111;	// Front end held
	localparam logic [6:0] EN_NONE = 7'b0000000;
	localparam logic [3:0] C_OK = 4'b1100;	// {iCacheOk,dCacheOk,mem1Wait,mulBusy}

	logic clk = 1'b0;
	logic arstN;
	logic idValid, idRfWr, idDmRd, idCp0Rd, idBjOp, idMux3Sel, alu1Sel;
	regNumT idRs, idRt, idRsCmp, idRtCmp, idRd;
	logic iCacheDataOk, dCacheDataOk, mem1WaitOp, mulBusy, mem1Exc;
	fwdSelT rsExSel, rtExSel, rsIdSel, rtIdSel, rsCmpSel, rtCmpSel, rsAluSel, rtAluSel;
	logic pcWr, pfIfWr, ifIdWr, idExWr, exMem1Wr, mem1Mem2Wr, mem2WbWr;
	logic bubbleSel, dataStall, wholeStall;

	// Stimulus table, one row per cycle
	logic tValid[N_ROWS], tWr[N_ROWS], tLd[N_ROWS], tCp0[N_ROWS], tBj[N_ROWS];
	logic tExc[N_ROWS], tRnd[N_ROWS], tBub[N_ROWS];
	logic [1:0] tMask[N_ROWS];	// {idMux3Sel, alu1Sel}
	logic [3:0] tCond[N_ROWS];
	logic [6:0] tEn[N_ROWS];
	regNumT tRs[N_ROWS], tRt[N_ROWS], tRd[N_ROWS];
	fwdSelT tRsEx[N_ROWS], tRsId[N_ROWS];
	int rowCount = 0;

	// Writer model of EX, MEM1, MEM2 and WB
	regNumT mExRd, mM1Rd, mM2Rd, mWbRd;
	logic mExW, mExL, mM1W, mM1L, mM2W, mM2L, mWbW;

	logic [31:0] seed = 32'h37e0_a36b;
	int selErrors = 0;
	int bitErrors = 0;
	int cycles = 0;

	hazardTop uut (.*);

	always #20 clk = ~clk;

	always @(posedge clk) begin
		cycles++;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("Timeout: simulation ran past %0d clock cycles", TIMEOUT_CYCLES);
			$display("RESULT: FAIL");
			$finish;
		end
	end

	function automatic logic [31:0] nextRand();
		seed = seed * 32'd1664525 + 32'd1013904223;
		return seed;
	endfunction

	function automatic fwdSelT modelExSel(input regNumT src);
		if (mExW && mExRd == src) return SEL_EX;	// Youngest first
		if (mM1W && mM1Rd == src) return SEL_MEM1;
		if (mM2W && mM2Rd == src) return SEL_MEM2;
		return SEL_NONE;
	endfunction

	function automatic fwdSelT modelIdSel(input regNumT src);
		if (mM1W && mM1Rd == src) return SEL_MEM1;
		if (mM2W && mM2Rd == src) return SEL_MEM2;
		if (mWbW && mWbRd == src) return SEL_WB;
		return SEL_NONE;
	endfunction

	task automatic checkSel(input string what, input fwdSelT got, input fwdSelT exp);
		if (got !== exp) begin
			selErrors++;
			$display("ERROR %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic checkBit(input string what, input logic got, input logic exp);
		if (got !== exp) begin
			bitErrors++;
			$display("ERROR %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	task automatic addRow(input logic v, input regNumT rs, input regNumT rt, input regNumT rd,
		input logic wr, input logic ld, input logic bj, input logic [1:0] mask,
		input logic [3:0] cond, input logic exc, input logic [6:0] en, input logic bub,
		input fwdSelT rsEx, input fwdSelT rsId);
		tValid[rowCount] = v;
		tRs[rowCount] = rs;
		tRt[rowCount] = rt;
		tRd[rowCount] = rd;
		tWr[rowCount] = wr;
		tLd[rowCount] = ld;
		tCp0[rowCount] = 1'b0;
		tBj[rowCount] = bj;
		tMask[rowCount] = mask;
		tCond[rowCount] = cond;
		tExc[rowCount] = exc;
		tEn[rowCount] = en;
		tBub[rowCount] = bub;
		tRsEx[rowCount] = rsEx;
		tRsId[rowCount] = rsId;
		tRnd[rowCount] = 1'b0;
		rowCount++;
	endtask

	// Filler row, registers limited to 0..7 so hits are frequent
	task automatic addRandom();
		logic [31:0] r;
		r = nextRand();
		addRow(r[17:16] != 2'b00, {2'b00, r[4:2]}, {2'b00, r[7:5]}, {2'b00, r[10:8]},
			r[11], r[12], r[13], r[15:14],
			{r[20:18] != 3'b000, r[23:21] != 3'b000, r[26:24] == 3'b000, r[29:27] == 3'b000},
			r[31:29] == 3'b111, EN_ALL, 1'b0, SEL_NONE, SEL_NONE);
		tCp0[rowCount-1] = r[28];
		tRnd[rowCount-1] = 1'b1;	// Expectations from the model only
	endtask

	task automatic applyRow(input int i);
		fwdSelT eRsEx, eRtEx;
		logic exHit, m1Hit, m2Hit, dStall, wStall, eBub;
		logic [6:0] eEn;
		logic [6:0] gotEn;
		{idValid, idRs, idRt} = {tValid[i], tRs[i], tRt[i]};
		{idRd, idRfWr, idDmRd} = {tRd[i], tWr[i], tLd[i]};
		idRsCmp = tRt[i];	// Compare sources crossed against rs/rt
		idRtCmp = tRs[i];
		{idCp0Rd, idBjOp, idMux3Sel, alu1Sel} = {tCp0[i], tBj[i], tMask[i]};
		{iCacheDataOk, dCacheDataOk, mem1WaitOp, mulBusy} = tCond[i];
		mem1Exc = tExc[i];
		#10;
		eRsEx = modelExSel(tRs[i]);
		eRtEx = modelExSel(tRt[i]);
		exHit = mExW && (mExRd == tRs[i] || mExRd == tRt[i]);
		m1Hit = mM1W && (mM1Rd == tRs[i] || mM1Rd == tRt[i]);
		m2Hit = mM2W && (mM2Rd == tRs[i] || mM2Rd == tRt[i]);
		dStall = tValid[i] && ((exHit && (mExL || tBj[i])) || (m1Hit && mM1L)
			|| (m2Hit && mM2L && tBj[i]));
		wStall = !tCond[i][3] || !tCond[i][2] || tCond[i][1] || tCond[i][0];
		eBub = 1'b0;
		if (tExc[i]) eEn = {5'b11111, tCond[i][2], tCond[i][2]};
		else if (wStall) eEn = EN_NONE;
		else if (dStall) begin
			eEn = EN_DATA;
			eBub = 1'b1;
		end else eEn = EN_ALL;
		checkSel("rsExSel", rsExSel, eRsEx);
		checkSel("rtExSel", rtExSel, eRtEx);
		checkSel("rsIdSel", rsIdSel, modelIdSel(tRs[i]));
		checkSel("rtIdSel", rtIdSel, modelIdSel(tRt[i]));
		checkSel("rsCmpSel", rsCmpSel, modelIdSel(tRt[i]));
		checkSel("rtCmpSel", rtCmpSel, modelIdSel(tRs[i]));
		checkSel("rsAluSel", rsAluSel, tMask[i][0] ? SEL_NONE : eRsEx);
		checkSel("rtAluSel", rtAluSel, tMask[i][1] ? SEL_NONE : eRtEx);
		gotEn = {pcWr, pfIfWr, ifIdWr, idExWr, exMem1Wr, mem1Mem2Wr, mem2WbWr};
		for (int b = 0; b < 7; b++) begin
			checkBit($sformatf("enable bit %0d", b), gotEn[b], eEn[b]);
			if (!tRnd[i]) checkBit($sformatf("row %0d enable bit %0d", i, b), gotEn[b], tEn[i][b]);
		end
		checkBit("bubbleSel", bubbleSel, eBub);
		checkBit("dataStall", dataStall, dStall);
		checkBit("wholeStall", wholeStall, wStall);
		if (!tRnd[i]) begin
			checkBit($sformatf("row %0d bubbleSel", i), bubbleSel, tBub[i]);
			checkSel($sformatf("row %0d rsExSel", i), rsExSel, tRsEx[i]);
			checkSel($sformatf("row %0d rsIdSel", i), rsIdSel, tRsId[i]);
		end
		// Advance the model, oldest stage first
		if (eEn[0]) {mWbRd, mWbW} = {mM2Rd, mM2W};
		if (eEn[1]) {mM2Rd, mM2W, mM2L} = {mM1Rd, mM1W, mM1L};
		if (eEn[2]) {mM1Rd, mM1W, mM1L} = {mExRd, mExW && !tExc[i], mExL && !tExc[i]};
		if (eEn[3]) begin
			mExRd = tRd[i];
			mExW = !(eBub || !tValid[i] || tExc[i]) && tWr[i] && (tRd[i] != REG_ZERO);
			mExL = !(eBub || !tValid[i] || tExc[i]) && (tLd[i] || tCp0[i]);
		end
	endtask

	initial begin
		{arstN, idValid, idRfWr, idDmRd, idCp0Rd, idBjOp, idMux3Sel, alu1Sel} = 8'b0;
		{idRs, idRt, idRsCmp, idRtCmp, idRd} = '0;
		{iCacheDataOk, dCacheDataOk, mem1WaitOp, mulBusy, mem1Exc} = 5'b11000;
		{mExW, mExL, mM1W, mM1L, mM2W, mM2L, mWbW} = 7'b0;
		{mExRd, mM1Rd, mM2Rd, mWbRd} = '0;
		addRow(0, 5'd0, 5'd0, 5'd0, 0, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_NONE, SEL_NONE);
		addRow(1, 5'd1, 5'd2, 5'd3, 1, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_NONE, SEL_NONE);
		addRow(1, 5'd3, 5'd4, 5'd5, 1, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_EX, SEL_NONE);
		addRow(1, 5'd3, 5'd5, 5'd3, 1, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_MEM1, SEL_MEM1);
		addRow(1, 5'd3, 5'd0, 5'd0, 1, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_EX, SEL_MEM2);
		addRow(1, 5'd0, 5'd0, 5'd6, 1, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_NONE, SEL_NONE);
		addRow(1, 5'd6, 5'd6, 5'd7, 1, 0, 0, 2'b11, C_OK, 0, EN_ALL, 0, SEL_EX, SEL_NONE);
		addRow(1, 5'd3, 5'd1, 5'd8, 1, 1, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_NONE, SEL_WB);
		addRow(1, 5'd8, 5'd9, 5'd10, 1, 0, 0, 2'b00, C_OK, 0, EN_DATA, 1, SEL_EX, SEL_NONE);
		addRow(1, 5'd8, 5'd9, 5'd10, 1, 0, 0, 2'b00, C_OK, 0, EN_DATA, 1, SEL_MEM1, SEL_MEM1);
		addRow(1, 5'd8, 5'd9, 5'd10, 1, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_MEM2, SEL_MEM2);
		addRow(1, 5'd10, 5'd8, 5'd11, 1, 0, 0, 2'b00, 4'b0100, 0, EN_NONE, 0, SEL_EX, SEL_NONE);
		addRow(1, 5'd10, 5'd8, 5'd11, 1, 0, 0, 2'b00, 4'b1101, 0, EN_NONE, 0, SEL_EX, SEL_NONE);
		addRow(1, 5'd10, 5'd8, 5'd11, 1, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_EX, SEL_NONE);
		addRow(1, 5'd11, 5'd10, 5'd12, 1, 0, 0, 2'b00, 4'b1101, 1, EN_ALL, 0, SEL_EX, SEL_NONE);
		addRow(1, 5'd11, 5'd10, 5'd0, 0, 0, 0, 2'b00, C_OK, 0, EN_ALL, 0, SEL_NONE, SEL_NONE);
		while (rowCount < N_ROWS) addRandom();
		repeat (RESET_CYCLES) @(posedge clk);
		@(negedge clk);
		arstN = 1'b1;
		for (int i = 0; i < N_ROWS; i++) begin
			@(negedge clk);
			applyRow(i);
		end
		@(negedge clk);
		$display("Errors: select %0d, bit %0d", selErrors, bitErrors);
		if (selErrors + bitErrors == 0) begin
			$display("RESULT: PASS");
		end else begin
			$display("RESULT: FAIL");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== verilog.f ====
hdl/regPkg.sv
hdl/ctrlPkg.sv
hdl/issueTracker.sv
hdl/bypassSelect.sv
hdl/stallControl.sv
hdl/hazardTop.sv
sim/hazardTop_assert.sv
sim/hazardTop_tb.sv
